// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_top
FLIST      ?= mini_soc.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: mini_soc.f
+incdir+tests
src/soc_map_pkg.sv
src/bus_pkg.sv
src/addr_decoder.sv
src/mem_bank.sv
src/rsp_collector.sv
src/mini_soc_top.sv
tests/tb_top.sv

// File: src/addr_decoder.sv
`default_nettype none

module addr_decoder import soc_map_pkg::*; import bus_pkg::*; (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  logic                         req_valid_i,
  input  bus_req_t                     req_i,
  input  logic                         credit_i,
  output bank_req_t [NUM_BANKS-1:0]    bank_req_o,
  output order_t                       order_o
);

  logic [ADDR_W-1:0]          offset;
  logic [ADDR_W-1:0]          stride_off;
  logic                       in_span;
  logic                       in_window;
  logic                       hit;
  bank_idx_t                  bank_sel;
  word_idx_t                  word_sel;
  bank_req_t                  next_req;

  bank_req_t [NUM_BANKS-1:0]  bank_req_q;
  order_t                     order_q;
  logic [CNT_W-1:0]           outstanding_q;

  // --------------------
  // address decode
  // --------------------
  assign offset     = req_i.addr - BANK_BASE;
  assign in_span    = (req_i.addr >= BANK_BASE) && (offset < MAP_SPAN);
  assign bank_sel   = bank_idx_t'(offset / BANK_STRIDE);
  assign stride_off = offset % BANK_STRIDE;
  // upper part of each stride is a hole
  assign in_window  = (stride_off >> BYTE_OFF_W) < ADDR_W'(BANK_WORDS);
  assign word_sel   = word_idx_t'(stride_off >> BYTE_OFF_W);
  assign hit        = in_span && in_window;

  assign next_req = '{
    valid: 1'b1,
    op:    req_i.op,
    word:  word_sel,
    wdata: req_i.wdata,
    strb:  req_i.strb
  };

  // --------------------
  // request register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_req_q <= '0;
      order_q    <= '0;
    end else begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        bank_req_q[i].valid <= 1'b0;
      end
      // every accepted request leaves exactly one order entry
      order_q.valid <= req_valid_i;
      order_q.err   <= ~hit;
      order_q.bank  <= bank_sel;
      if (req_valid_i && hit) begin
        bank_req_q[bank_sel] <= next_req;
      end
    end
  end

  assign bank_req_o = bank_req_q;
  assign order_o    = order_q;

  // requests issued but not yet answered by a credit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      case ({req_valid_i, credit_i})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  a_credit_limit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> (outstanding_q < CNT_W'(NUM_CREDITS))
  ) else $error("host issued a request with %0d already outstanding", outstanding_q);

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  import soc_map_pkg::*;

  // --------------------
  // encodings
  // --------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } opcode_e;

  typedef enum logic {
    ST_OKAY   = 1'b0,
    ST_DECERR = 1'b1
  } status_e;

  // --------------------
  // transactions
  // --------------------
  // host request, one word per beat
  typedef struct packed {
    opcode_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   strb;
  } bus_req_t;

  // decoded request to a single bank, valid for one cycle
  typedef struct packed {
    logic                valid;
    opcode_e             op;
    word_idx_t           word;
    logic [DATA_W-1:0]   wdata;
    logic [STRB_W-1:0]   strb;
  } bank_req_t;

  typedef struct packed {
    status_e             status;
    logic [DATA_W-1:0]   rdata;
  } bus_rsp_t;

  // one in-order tracking entry, err means no bank holds the answer
  typedef struct packed {
    logic                valid;
    logic                err;
    bank_idx_t           bank;
  } order_t;

endpackage

`default_nettype wire

// File: src/mem_bank.sv
`default_nettype none

module mem_bank import soc_map_pkg::*; import bus_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  bank_req_t   bank_req_i,
  output bus_rsp_t    bank_rsp_o,
  output logic        bank_valid_o,
  input  logic        bank_pop_i
);

  logic [DATA_W-1:0]  mem_q [BANK_WORDS];
  logic [DATA_W-1:0]  rd_word;
  logic [DATA_W-1:0]  wr_word;

  bus_rsp_t           fifo_q [NUM_CREDITS];
  bus_rsp_t           push_rsp;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               push;
  logic               pop;

  // --------------------
  // sram array
  // --------------------
  assign rd_word = mem_q[bank_req_i.word];

  // merge enabled bytes over the old word
  always_comb begin
    for (int b = 0; b < STRB_W; b++) begin
      wr_word[b*8 +: 8] = bank_req_i.strb[b] ? bank_req_i.wdata[b*8 +: 8]
                                             : rd_word[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_req_i.valid && (bank_req_i.op == OP_WRITE)) begin
      mem_q[bank_req_i.word] <= wr_word;
    end
  end

  // writes answer with zero data
  assign push_rsp.status = ST_OKAY;
  assign push_rsp.rdata  = (bank_req_i.op == OP_READ) ? rd_word : '0;

  // --------------------
  // response fifo
  // --------------------
  assign push = bank_req_i.valid;
  assign pop  = bank_pop_i && (cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= push_rsp;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign bank_rsp_o   = fifo_q[rd_ptr_q];
  assign bank_valid_o = (cnt_q != '0);

  // credits upstream bound the fill level
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bank_req_i.valid |-> (cnt_q != CNT_W'(NUM_CREDITS))
  ) else $error("bank response FIFO overflow");

endmodule

`default_nettype wire

// File: src/mini_soc_top.sv
`default_nettype none

module mini_soc_top import soc_map_pkg::*; import bus_pkg::*; (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  logic        req_valid_i,
  input  bus_req_t    req_i,
  output logic        credit_o,
  output logic        rsp_valid_o,
  output bus_rsp_t    rsp_o,
  input  logic        rsp_ready_i
);

  bank_req_t [NUM_BANKS-1:0]  bank_req;
  bus_rsp_t  [NUM_BANKS-1:0]  bank_rsp;
  logic      [NUM_BANKS-1:0]  bank_valid;
  logic      [NUM_BANKS-1:0]  bank_pop;
  order_t                     order;
  logic                       credit;

  // --------------------
  // request side
  // --------------------
  addr_decoder i_addr_decoder (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .credit_i    ( credit      ),
    .bank_req_o  ( bank_req    ),
    .order_o     ( order       )
  );

  // --------------------
  // memory banks
  // --------------------
  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    mem_bank i_mem_bank (
      .clk_i        ( clk_i         ),
      .rst_ni       ( rst_ni        ),
      .bank_req_i   ( bank_req[i]   ),
      .bank_rsp_o   ( bank_rsp[i]   ),
      .bank_valid_o ( bank_valid[i] ),
      .bank_pop_i   ( bank_pop[i]   )
    );
  end

  // --------------------
  // response side
  // --------------------
  rsp_collector i_rsp_collector (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .order_i      ( order       ),
    .bank_rsp_i   ( bank_rsp    ),
    .bank_valid_i ( bank_valid  ),
    .bank_pop_o   ( bank_pop    ),
    .rsp_valid_o  ( rsp_valid_o ),
    .rsp_o        ( rsp_o       ),
    .rsp_ready_i  ( rsp_ready_i ),
    .credit_o     ( credit      )
  );

  // credit also feeds the decoder's outstanding count
  assign credit_o = credit;

endmodule

`default_nettype wire

// File: src/rsp_collector.sv
`default_nettype none

module rsp_collector import soc_map_pkg::*; import bus_pkg::*; (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  order_t                       order_i,
  input  bus_rsp_t [NUM_BANKS-1:0]     bank_rsp_i,
  input  logic [NUM_BANKS-1:0]         bank_valid_i,
  output logic [NUM_BANKS-1:0]         bank_pop_o,
  output logic                         rsp_valid_o,
  output bus_rsp_t                     rsp_o,
  input  logic                         rsp_ready_i,
  output logic                         credit_o
);

  order_t             ord_q [NUM_CREDITS];
  logic [PTR_W-1:0]   ord_wr_q;
  logic [PTR_W-1:0]   ord_rd_q;
  logic [CNT_W-1:0]   ord_cnt_q;
  order_t             head;
  logic               ord_empty;

  logic               head_ready;
  logic               out_free;
  logic               take;
  bus_rsp_t           next_rsp;

  bus_rsp_t           rsp_q;
  logic               rsp_valid_q;
  logic               credit_q;

  // --------------------
  // order fifo
  // --------------------
  always_ff @(posedge clk_i) begin
    if (order_i.valid) begin
      ord_q[ord_wr_q] <= order_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ord_wr_q  <= '0;
      ord_rd_q  <= '0;
      ord_cnt_q <= '0;
    end else begin
      if (order_i.valid) begin
        ord_wr_q <= (ord_wr_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : ord_wr_q + 1'b1;
      end
      if (take) begin
        ord_rd_q <= (ord_rd_q == PTR_W'(NUM_CREDITS - 1)) ? '0 : ord_rd_q + 1'b1;
      end
      case ({order_i.valid, take})
        2'b10:   ord_cnt_q <= ord_cnt_q + 1'b1;
        2'b01:   ord_cnt_q <= ord_cnt_q - 1'b1;
        default: ord_cnt_q <= ord_cnt_q;
      endcase
    end
  end

  assign head      = ord_q[ord_rd_q];
  assign ord_empty = (ord_cnt_q == '0);

  // --------------------
  // drain in request order
  // --------------------
  // error entries need no bank, bank entries wait for their data
  assign head_ready = !ord_empty && (head.err || bank_valid_i[head.bank]);
  assign out_free   = !rsp_valid_q || rsp_ready_i;
  assign take       = out_free && head_ready;

  always_comb begin
    bank_pop_o = '0;
    if (take && !head.err) begin
      bank_pop_o[head.bank] = 1'b1;
    end
  end

  assign next_rsp = head.err ? '{status: ST_DECERR, rdata: '0} : bank_rsp_i[head.bank];

  always_ff @(posedge clk_i) begin
    if (take) begin
      rsp_q <= next_rsp;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      credit_q    <= 1'b0;
    end else begin
      // one credit back per completed handshake
      credit_q <= rsp_valid_q && rsp_ready_i;
      if (take) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign credit_o    = credit_q;

  a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
  ) else $error("response changed while stalled");

endmodule

`default_nettype wire

// File: src/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  // --------------------
  // bus widths
  // --------------------
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned STRB_W     = DATA_W / 8;
  // byte address bits below the word index
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);

  // --------------------
  // memory map
  // --------------------
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 256;

  // bank 0 window start, the others follow one stride apart
  localparam logic [ADDR_W-1:0] BANK_BASE   = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] BANK_STRIDE = 32'h0000_1000;
  // bytes covered by all bank windows together
  localparam logic [ADDR_W-1:0] MAP_SPAN    = ADDR_W'(NUM_BANKS) * BANK_STRIDE;

  // --------------------
  // flow control
  // --------------------
  // also the depth of every response and order FIFO
  localparam int unsigned NUM_CREDITS = 4;
  localparam int unsigned PTR_W       = $clog2(NUM_CREDITS);
  localparam int unsigned CNT_W       = $clog2(NUM_CREDITS + 1);

  typedef logic [$clog2(NUM_BANKS)-1:0]  bank_idx_t;
  typedef logic [$clog2(BANK_WORDS)-1:0] word_idx_t;

endpackage

`default_nettype wire

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference memory, one row per bank
logic [DATA_W-1:0] ref_mem [NUM_BANKS][BANK_WORDS];

// expected responses in issue order
bus_rsp_t exp_q[$];
string    exp_name_q[$];

// enabled bytes take the new data
function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [STRB_W-1:0] strb);
  logic [DATA_W-1:0] res;
  for (int i = 0; i < STRB_W; i++) begin
    res[i*8 +: 8] = strb[i] ? new_word[i*8 +: 8] : old_word[i*8 +: 8];
  end
  return res;
endfunction

// bank window lookup, 0 means unmapped
function automatic bit map_addr(input logic [ADDR_W-1:0] addr, output int bank,
                                output int word);
  logic [ADDR_W-1:0] off;
  bank = 0;
  word = 0;
  if (addr < BANK_BASE) begin
    return 1'b0;
  end
  off  = addr - BANK_BASE;
  bank = int'(off / BANK_STRIDE);
  word = int'((off % BANK_STRIDE) / STRB_W);
  return (bank < NUM_BANKS) && (word < BANK_WORDS);
endfunction

task automatic clear_memory();
  for (int b = 0; b < NUM_BANKS; b++) begin
    for (int w = 0; w < BANK_WORDS; w++) begin
      ref_mem[b][w] = '0;
    end
  end
endtask

// apply one request to the model and queue what the DUT must answer
task automatic push_expected(input string name, input bus_req_t req);
  int       bank;
  int       word;
  bus_rsp_t rsp;
  rsp.status = ST_OKAY;
  rsp.rdata  = '0;
  if (!map_addr(req.addr, bank, word)) begin
    rsp.status = ST_DECERR;
  end else if (req.op == OP_WRITE) begin
    ref_mem[bank][word] = merge_bytes(ref_mem[bank][word], req.wdata, req.strb);
  end else begin
    rsp.rdata = ref_mem[bank][word];
  end
  exp_q.push_back(rsp);
  exp_name_q.push_back(name);
endtask

`endif

// File: tests/tb_top.sv
`default_nettype none

module tb_top import soc_map_pkg::*; import bus_pkg::*; ();

  localparam int WIN_WORDS      = 16;
  localparam int N_STRB_PAIRS   = 32;
  localparam int N_ERR          = 24;
  localparam int N_MIX          = 96;
  localparam int N_OPS          = 2 * NUM_BANKS * WIN_WORDS + 2 * N_STRB_PAIRS
                                  + 2 * N_ERR + N_MIX;
  localparam int TIMEOUT_CYCLES = 20 * N_OPS + 100;

  logic     clk_i       = 1'b0;
  logic     rst_ni      = 1'b0;
  logic     req_valid_i = 1'b0;
  bus_req_t req_i       = '0;
  logic     rsp_ready_i = 1'b0;
  logic     credit_o;
  logic     rsp_valid_o;
  bus_rsp_t rsp_o;

  integer   seed = 23;
  bus_req_t req_list[$];
  string    name_list[$];
  int       issued        = 0;
  int       credits_spent = 0;
  int       credit_pulses = 0;
  int       handshakes    = 0;
  int       cycles        = 0;
  int       rsp_errs      = 0;
  int       count_errs    = 0;
  int       other_errs    = 0;
  bus_rsp_t exp_rsp;
  string    exp_name;

  `include "tb_model.svh"

  mini_soc_top dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .credit_o    ( credit_o    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i )
  );

  always #20 clk_i = ~clk_i;

  // --------------------
  // helpers
  // --------------------
  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input int unsigned bank,
                                                  input int unsigned word);
    return BANK_BASE + bank * BANK_STRIDE + word * STRB_W;
  endfunction

  // below the map, in a stride hole, or past the last bank
  function automatic logic [ADDR_W-1:0] bad_addr(input int unsigned kind);
    if (kind == 0) begin
      return rnd(BANK_BASE) & ~32'h3;
    end else if (kind == 1) begin
      return word_addr(rnd(NUM_BANKS), BANK_WORDS + rnd(BANK_STRIDE / STRB_W - BANK_WORDS));
    end
    return word_addr(NUM_BANKS, rnd(1024));
  endfunction

  function automatic int credits_held();
    return int'(NUM_CREDITS) + credit_pulses - credits_spent;
  endfunction

  task automatic add_op(input string name, input bus_req_t req);
    req_list.push_back(req);
    name_list.push_back(name);
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %s/%h, actual %s/%h", name, exp.status.name(),
               exp.rdata, act.status.name(), act.rdata);
      rsp_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      count_errs++;
    end
  endtask

  // --------------------
  // operation list
  // --------------------
  task automatic build_ops();
    bus_req_t r;
    r = '0;
    // full words into every window and then read back
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < WIN_WORDS; w++) begin
        r.op    = OP_WRITE;
        r.addr  = word_addr(b, w);
        r.wdata = $random(seed);
        r.strb  = '1;
        add_op("preload write", r);
      end
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int w = 0; w < WIN_WORDS; w++) begin
        r.op   = OP_READ;
        r.addr = word_addr(b, w);
        add_op("preload readback", r);
      end
    end
    // partial strobes each followed by a read of the same word
    for (int k = 0; k < N_STRB_PAIRS; k++) begin
      r.op    = OP_WRITE;
      r.addr  = word_addr(rnd(NUM_BANKS), rnd(WIN_WORDS));
      r.wdata = $random(seed);
      r.strb  = STRB_W'(1 + rnd(14));
      add_op("strobe write", r);
      r.op = OP_READ;
      add_op("strobe readback", r);
    end
    for (int k = 0; k < N_ERR; k++) begin
      r.op    = (rnd(2) == 0) ? OP_READ : OP_WRITE;
      r.addr  = bad_addr(k % 3);
      r.wdata = $random(seed);
      r.strb  = '1;
      add_op("decode error", r);
      r.op   = OP_READ;
      r.addr = word_addr(rnd(NUM_BANKS), rnd(WIN_WORDS));
      add_op("readback after error", r);
    end
    // mixed traffic with errors interleaved
    for (int k = 0; k < N_MIX; k++) begin
      r.op    = (rnd(2) == 0) ? OP_READ : OP_WRITE;
      r.addr  = (rnd(4) == 0) ? bad_addr(rnd(3)) : word_addr(rnd(NUM_BANKS), rnd(WIN_WORDS));
      r.wdata = $random(seed);
      r.strb  = STRB_W'(rnd(16));
      add_op("ordering mix", r);
    end
  endtask

  // --------------------
  // host side
  // --------------------
  // outputs read here still hold the values of the cycle that just ended
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (credit_o) begin
        credit_pulses++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        handshakes++;
        if (exp_q.size() == 0) begin
          $display("response handshake arrived with no request outstanding");
          other_errs++;
        end else begin
          exp_rsp  = exp_q.pop_front();
          exp_name = exp_name_q.pop_front();
          check_rsp(exp_name, exp_rsp, rsp_o);
        end
      end
      rsp_ready_i <= (rnd(10) < 7);
      if (issued < N_OPS && credits_held() > 0 && rnd(4) != 0) begin
        req_valid_i <= 1'b1;
        req_i       <= req_list[issued];
        push_expected(name_list[issued], req_list[issued]);
        credits_spent++;
        issued++;
      end else begin
        req_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d responses received",
               cycles, handshakes, N_OPS);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clear_memory();
    build_ops();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (handshakes < N_OPS) begin
      @(posedge clk_i);
    end
    // last credit pulse trails its handshake by one cycle
    repeat (3) @(posedge clk_i);
    check_count("requests issued", N_OPS, issued);
    check_count("responses received", N_OPS, handshakes);
    check_count("credit pulses", handshakes, credit_pulses);
    check_count("credits held at end", NUM_CREDITS, credits_held());
    check_count("expected queue left", 0, exp_q.size());
    $display("errors: %0d response, %0d count, %0d protocol", rsp_errs, count_errs,
             other_errs);
    if (rsp_errs + count_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
